//--- execPkg.sv
package execPkg;

  localparam int xlen       = 64;  // RV64 data width
  localparam int wordLen    = 32;  // width of the *w ops
  localparam int shamtBits  = 6;   // full width shift field
  localparam int shamtBitsW = 5;   // word shift field

  typedef logic [xlen-1:0] xword_t;

  // bit 5 marks a word op
  typedef enum logic [5:0] {
    opSll   = 6'd1,
    opSrl   = 6'd2,
    opSra   = 6'd3,
    opAdd   = 6'd4,   // also load/store address
    opSub   = 6'd5,
    opXor   = 6'd14,
    opOr    = 6'd15,
    opAnd   = 6'd16,
    opSlt   = 6'd17,
    opSltu  = 6'd18,
    opAuipc = 6'd19,
    opLui   = 6'd20,
    opJalr  = 6'd21,
    opJal   = 6'd22,
    opBeq   = 6'd23,
    opBne   = 6'd24,
    opBlt   = 6'd25,
    opBge   = 6'd26,
    opBltu  = 6'd27,
    opBgeu  = 6'd28,
    opSllw  = 6'd33,
    opSrlw  = 6'd34,
    opSraw  = 6'd35,
    opAddw  = 6'd36,
    opSubw  = 6'd37
  } aluOp_e;

  // bit 2 picks lane 2, bits 1:0 pick wb or mem
  typedef enum logic [2:0] {
    fwdReg  = 3'b000,
    fwdWb1  = 3'b001,
    fwdMem1 = 3'b010,
    fwdWb2  = 3'b101,
    fwdMem2 = 3'b110
  } fwdSel_e;

  typedef struct packed {
    xword_t   rd1;     // register file port 1
    xword_t   rd2;     // register file port 2
    xword_t   pc;
    xword_t   imm;     // sign-extended immediate
    aluOp_e   aluOp;
    logic     aluSrc;  // 1 selects imm as operand B
    fwdSel_e  fwdA;
    fwdSel_e  fwdB;
  } laneIssue_t;

  typedef struct packed {
    xword_t memRes1;
    xword_t memRes2;
    xword_t wbRes1;
    xword_t wbRes2;
  } bypass_t;

  typedef struct packed {
    xword_t aluResult;
    xword_t writeData;  // store data
  } laneResult_t;

  typedef struct packed {
    logic   take;
    xword_t target;
  } redirect_t;

endpackage

//--- laneAlu.sv
`timescale 1ns/10ps

module laneAlu (
  input  execPkg::aluOp_e aluOp,
  input  execPkg::xword_t srcA,
  input  execPkg::xword_t srcB,
  output execPkg::xword_t result,
  output logic            cond
);
  import execPkg::*;

  logic [shamtBits-1:0]  shamt;
  logic [shamtBitsW-1:0] shamtW;
  logic [wordLen-1:0]    wordA;
  logic [wordLen-1:0]    wordB;
  logic [wordLen-1:0]    wordRes;
  xword_t                wordExt;
  logic                  ltSigned;
  logic                  ltUnsigned;
  logic                  isEqual;

  assign shamt  = srcB[shamtBits-1:0];
  assign shamtW = srcB[shamtBitsW-1:0];
  assign wordA  = srcA[wordLen-1:0];
  assign wordB  = srcB[wordLen-1:0];

  // compares shared by slt* and the branches
  assign ltSigned   = $signed(srcA) < $signed(srcB);
  assign ltUnsigned = srcA < srcB;
  assign isEqual    = srcA == srcB;

  // 32-bit datapath for the word forms
  always_comb begin
    case (aluOp)
      opSllw:  wordRes = wordA << shamtW;
      opSrlw:  wordRes = wordA >> shamtW;
      opSraw:  wordRes = $signed(wordA) >>> shamtW;  // arithmetic on 32 bits
      opAddw:  wordRes = wordA + wordB;
      opSubw:  wordRes = wordA - wordB;
      default: wordRes = '0;
    endcase
  end

  assign wordExt = {{(xlen-wordLen){wordRes[wordLen-1]}}, wordRes};  // sign-extend from bit 31

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (aluOp)
      opSll:   result = srcA << shamt;
      opSrl:   result = srcA >> shamt;
      opSra:   result = $signed(srcA) >>> shamt;
      opAdd:   result = srcA + srcB;
      opSub:   result = srcA - srcB;
      opXor:   result = srcA ^ srcB;
      opOr:    result = srcA | srcB;
      opAnd:   result = srcA & srcB;
      opSlt:   result = xword_t'(ltSigned);
      opSltu:  result = xword_t'(ltUnsigned);
      opAuipc: result = srcA + srcB;  // srcA carries pc
      opLui:   result = srcB;
      opBeq:   cond = isEqual;
      opBne:   cond = !isEqual;
      opBlt:   cond = ltSigned;
      opBge:   cond = !ltSigned;
      opBltu:  cond = ltUnsigned;
      opBgeu:  cond = !ltUnsigned;
      opSllw,
      opSrlw,
      opSraw,
      opAddw,
      opSubw:  result = wordExt;
      default: begin
        // jal, jalr and unknown codes leave result at zero
        result = '0;
        cond   = 1'b0;
      end
    endcase
  end

endmodule

//--- execLane.sv
`timescale 1ns/10ps

module execLane (
  input  execPkg::laneIssue_t  issue,
  input  execPkg::bypass_t     bypass,
  output execPkg::laneResult_t result,
  output execPkg::redirect_t   redirect
);
  import execPkg::*;

  xword_t fwdOpA;      // operand A after forwarding
  xword_t storeData;   // operand B after forwarding
  xword_t srcA;
  xword_t srcB;
  xword_t aluOut;
  xword_t targetBase;
  logic   cmpTrue;
  logic   isJal;
  logic   isJalr;
  logic   isBranch;

  // unknown select codes fall back to the register value
  function automatic xword_t pickFwd(fwdSel_e sel, xword_t regVal, bypass_t byp);
    case (sel)
      fwdWb1:  return byp.wbRes1;
      fwdWb2:  return byp.wbRes2;
      fwdMem1: return byp.memRes1;
      fwdMem2: return byp.memRes2;
      default: return regVal;
    endcase
  endfunction

  assign fwdOpA    = pickFwd(issue.fwdA, issue.rd1, bypass);
  assign storeData = pickFwd(issue.fwdB, issue.rd2, bypass);

  assign srcA = (issue.aluOp == opAuipc) ? issue.pc : fwdOpA;
  assign srcB = issue.aluSrc ? issue.imm : storeData;

  laneAlu alu_i (
    .aluOp  (issue.aluOp),
    .srcA   (srcA),
    .srcB   (srcB),
    .result (aluOut),
    .cond   (cmpTrue)
  );

  assign isJal    = issue.aluOp == opJal;
  assign isJalr   = issue.aluOp == opJalr;
  assign isBranch = issue.aluOp inside {opBeq, opBne, opBlt, opBge, opBltu, opBgeu};

  // jalr is register relative, everything else pc relative
  assign targetBase      = isJalr ? fwdOpA : issue.pc;
  assign redirect.target = targetBase + issue.imm;
  assign redirect.take   = isJal | isJalr | (isBranch & cmpTrue);

  assign result.aluResult = aluOut;
  assign result.writeData = storeData;

endmodule

//--- branchResolve.sv
`timescale 1ns/10ps

module branchResolve (
  input  execPkg::redirect_t redirect1,
  input  execPkg::redirect_t redirect2,
  output execPkg::redirect_t redirect,
  output logic               redirectLane
);

  // lane 1 holds the older instruction, so it wins a tie
  always_comb begin
    if (redirect1.take) begin
      redirect     = redirect1;
      redirectLane = 1'b0;
    end else if (redirect2.take) begin
      redirect     = redirect2;
      redirectLane = 1'b1;
    end else begin
      redirect     = '0;  // no take, no stale target
      redirectLane = 1'b0;
    end
  end

endmodule

//--- execStage.sv
`timescale 1ns/10ps

module execStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 req,
  input  execPkg::laneIssue_t  issue1,
  input  execPkg::laneIssue_t  issue2,
  input  execPkg::bypass_t     bypass,
  output logic                 ack,
  output execPkg::laneResult_t result1,
  output execPkg::laneResult_t result2,
  output execPkg::redirect_t   redirect,
  output logic                 redirectLane
);
  import execPkg::*;

  laneResult_t laneRes1;
  laneResult_t laneRes2;
  redirect_t   laneRedir1;
  redirect_t   laneRedir2;
  redirect_t   finalRedir;
  logic        finalLane;
  logic        capture;

  // inputs are held stable by the driver while req is up
  assign capture = req & ~ack;

  execLane lane1_i (
    .issue    (issue1),
    .bypass   (bypass),
    .result   (laneRes1),
    .redirect (laneRedir1)
  );

  execLane lane2_i (
    .issue    (issue2),
    .bypass   (bypass),
    .result   (laneRes2),
    .redirect (laneRedir2)
  );

  branchResolve resolve_i (
    .redirect1    (laneRedir1),
    .redirect2    (laneRedir2),
    .redirect     (finalRedir),
    .redirectLane (finalLane)
  );

  // four-phase handshake, one pair in flight
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ack <= 1'b0;
    end else if (capture) begin
      ack <= 1'b1;  // same edge as the capture
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  // outputs only move on a capture edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result1      <= '0;
      result2      <= '0;
      redirect     <= '0;
      redirectLane <= 1'b0;
    end else if (capture) begin
      result1      <= laneRes1;
      result2      <= laneRes2;
      redirect     <= finalRedir;
      redirectLane <= finalLane;
    end
  end

endmodule

//--- execStage_props.sv
`timescale 1ns/10ps

module execStageProps (
  input logic                 clk,
  input logic                 rstN,
  input logic                 req,
  input logic                 ack,
  input execPkg::laneResult_t result1,
  input execPkg::laneResult_t result2,
  input execPkg::redirect_t   redirect,
  input logic                 redirectLane
);

  int failCount = 0;  // tally of failed properties

  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    $rose(ack) |-> $past(req))
  else begin
    failCount++;
    $error("ack rose although req was low on the edge before");
  end

  ackFallNeedsIdle: assert property (@(posedge clk) disable iff (!rstN)
    $fell(ack) |-> !$past(req))
  else begin
    failCount++;
    $error("ack fell although req was still high on the edge before");
  end

  // no capture can happen while ack stays up
  outputsHeld: assert property (@(posedge clk) disable iff (!rstN)
    (ack && $past(ack)) |-> ($stable(result1) && $stable(result2) &&
                             $stable(redirect) && $stable(redirectLane)))
  else begin
    failCount++;
    $error("outputs changed while ack was held high");
  end

  noTakeInReset: assert property (@(posedge clk) !rstN |-> !redirect.take)
  else begin
    failCount++;
    $error("redirect.take was set while rstN was low");
  end

endmodule

bind execStage execStageProps props_i (
  .clk          (clk),
  .rstN         (rstN),
  .req          (req),
  .ack          (ack),
  .result1      (result1),
  .result2      (result2),
  .redirect     (redirect),
  .redirectLane (redirectLane)
);

//--- tbExecStage.sv
`timescale 1ns/10ps

module tbExecStage;
  import execPkg::*;

  localparam int ackTimeout = 20;  // cycles per handshake phase

  logic        clk;
  logic        rstN;
  logic        req;
  laneIssue_t  issue1;
  laneIssue_t  issue2;
  bypass_t     bypass;
  logic        ack;
  laneResult_t result1;
  laneResult_t result2;
  redirect_t   redirect;
  logic        redirectLane;

  logic [31:0] lfsrState;
  int          checkCount;
  int          mismatchCount;
  int          timeoutCount;

  aluOp_e  fullOps[12] = '{opSll, opSrl, opSra, opAdd, opSub, opXor, opOr, opAnd,
                           opSlt, opSltu, opAuipc, opLui};
  aluOp_e  wordOps[5]  = '{opSllw, opSrlw, opSraw, opAddw, opSubw};
  aluOp_e  ctlOps[8]   = '{opBeq, opBne, opBlt, opBge, opBltu, opBgeu, opJal, opJalr};
  fwdSel_e fwdCodes[7] = '{fwdReg, fwdWb1, fwdMem1, fwdWb2, fwdMem2,
                           fwdSel_e'(3'b011), fwdSel_e'(3'b111)};  // last two unused codes

  execStage dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois LFSR stepped once per bit
  function automatic logic nextBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic logic [63:0] randBits(int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], nextBit()};
    end
    return val;
  endfunction

  function automatic laneIssue_t randIssue(aluOp_e op);
    laneIssue_t  iss;
    logic [11:0] imm12;
    iss.rd1    = randBits(64);
    iss.rd2    = randBits(64);
    iss.pc     = randBits(62) << 2;
    imm12      = randBits(12);
    iss.imm    = {{52{imm12[11]}}, imm12};  // I-type style immediate
    iss.aluOp  = op;
    iss.aluSrc = 1'b0;
    iss.fwdA   = fwdReg;
    iss.fwdB   = fwdReg;
    return iss;
  endfunction

  function automatic bypass_t randBypass();
    bypass_t byp;
    byp.memRes1 = randBits(64);
    byp.memRes2 = randBits(64);
    byp.wbRes1  = randBits(64);
    byp.wbRes2  = randBits(64);
    return byp;
  endfunction

  function automatic xword_t selectSource(fwdSel_e sel, xword_t regVal, bypass_t byp);
    logic [2:0] code;
    code = sel;
    if (code == 3'b001) return byp.wbRes1;
    if (code == 3'b101) return byp.wbRes2;
    if (code == 3'b010) return byp.memRes1;
    if (code == 3'b110) return byp.memRes2;
    return regVal;
  endfunction

  // reference model of one lane
  task automatic modelLane(input laneIssue_t iss, input bypass_t byp,
                           output laneResult_t res, output redirect_t red);
    xword_t      a;
    xword_t      b;
    xword_t      store;
    logic [31:0] w;
    store         = selectSource(iss.fwdB, iss.rd2, byp);
    a             = selectSource(iss.fwdA, iss.rd1, byp);
    b             = iss.aluSrc ? iss.imm : store;
    w             = '0;
    res.aluResult = '0;
    res.writeData = store;
    red.take      = 1'b0;
    red.target    = ((iss.aluOp == opJalr) ? a : iss.pc) + iss.imm;
    case (iss.aluOp)
      opSll:   res.aluResult = a << b[5:0];
      opSrl:   res.aluResult = a >> b[5:0];
      opSra:   res.aluResult = $signed(a) >>> b[5:0];
      opAdd:   res.aluResult = a + b;
      opSub:   res.aluResult = a + ~b + 64'd1;
      opXor:   res.aluResult = a ^ b;
      opOr:    res.aluResult = a | b;
      opAnd:   res.aluResult = a & b;
      opSlt:   res.aluResult = {63'd0, ($signed(a) < $signed(b))};
      opSltu:  res.aluResult = {63'd0, (a < b)};
      opAuipc: res.aluResult = iss.pc + b;
      opLui:   res.aluResult = b;
      opSllw:  w = a[31:0] << b[4:0];
      opSrlw:  w = a[31:0] >> b[4:0];
      opSraw:  w = $signed(a[31:0]) >>> b[4:0];
      opAddw:  w = a[31:0] + b[31:0];
      opSubw:  w = a[31:0] - b[31:0];
      opJal,
      opJalr:  red.take = 1'b1;
      opBeq:   red.take = (a == b);
      opBne:   red.take = (a != b);
      opBlt:   red.take = ($signed(a) < $signed(b));
      opBge:   red.take = ($signed(a) >= $signed(b));
      opBltu:  red.take = (a < b);
      opBgeu:  red.take = (a >= b);
      default: ;
    endcase
    if (iss.aluOp inside {opSllw, opSrlw, opSraw, opAddw, opSubw}) begin
      res.aluResult = {{32{w[31]}}, w};
    end
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [127:0] expected, input logic [127:0] actual);
    checkCount++;
    assert (actual === expected)
    else begin
      mismatchCount++;
      $display("MISMATCH %s %s expected %h actual %h", testName, field, expected, actual);
    end
  endtask

  task automatic checkOutputs(input string testName, input laneResult_t expRes1,
                              input laneResult_t expRes2, input redirect_t expRed,
                              input logic expLane);
    checkValue(testName, "result1", expRes1, result1);
    checkValue(testName, "result2", expRes2, result2);
    checkValue(testName, "redirect", expRed, redirect);
    checkValue(testName, "redirectLane", expLane, redirectLane);
  endtask

  // one four-phase handshake entered and left 1 ns after a rising edge
  task automatic runPair(input string testName, input laneIssue_t i1, input laneIssue_t i2,
                         input bypass_t byp, input int holdCycles);
    laneResult_t expRes1;
    laneResult_t expRes2;
    redirect_t   expRed1;
    redirect_t   expRed2;
    redirect_t   expRed;
    logic        expLane;
    int          waitCycles;
    modelLane(i1, byp, expRes1, expRed1);
    modelLane(i2, byp, expRes2, expRed2);
    expRed  = expRed1.take ? expRed1 : (expRed2.take ? expRed2 : '0);
    expLane = !expRed1.take && expRed2.take;  // lane 1 is older
    issue1  = i1;
    issue2  = i2;
    bypass  = byp;
    req     = 1'b1;
    waitCycles = 0;
    do begin
      @(posedge clk);
      #1;
      waitCycles++;
    end while (!ack && waitCycles < ackTimeout);
    if (!ack) begin
      timeoutCount++;
      $display("timeout in %s: ack never rose after req went high", testName);
    end else begin
      checkValue(testName, "ack rise cycles", 1, waitCycles);
      checkOutputs(testName, expRes1, expRes2, expRed, expLane);
      if (holdCycles > 0) begin
        issue1 = randIssue(fullOps[randBits(4) % 12]);  // new inputs must not leak through
        issue2 = randIssue(wordOps[randBits(3) % 5]);
        bypass = randBypass();
        repeat (holdCycles) begin
          @(posedge clk);
          #1;
        end
        checkOutputs({testName, "Held"}, expRes1, expRes2, expRed, expLane);
      end
    end
    req = 1'b0;
    waitCycles = 0;
    do begin
      @(posedge clk);
      #1;
      waitCycles++;
    end while (ack && waitCycles < ackTimeout);
    if (ack) begin
      timeoutCount++;
      $display("timeout in %s: ack never fell after req went low", testName);
    end else begin
      checkValue(testName, "ack fall cycles", 1, waitCycles);
    end
  endtask

  initial begin
    laneIssue_t i1;
    laneIssue_t i2;
    lfsrState     = 32'heb1849d9;
    checkCount    = 0;
    mismatchCount = 0;
    timeoutCount  = 0;
    rstN   = 1'b0;
    req    = 1'b0;
    issue1 = '0;
    issue2 = '0;
    bypass = '0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkValue("reset", "ack", 0, ack);
    checkOutputs("reset", '0, '0, '0, 1'b0);

    foreach (fullOps[k]) begin
      repeat (4) begin
        i1 = randIssue(fullOps[k]);
        i2 = randIssue(fullOps[randBits(4) % 12]);
        i1.aluSrc = nextBit();
        runPair("fullWidth", i1, i2, randBypass(), 0);
      end
    end

    foreach (wordOps[k]) begin
      for (int n = 0; n < 6; n++) begin
        i1 = randIssue(wordOps[k]);
        i2 = randIssue(wordOps[(k + 1) % 5]);
        i1.rd1[31] = n[0];  // both signs of the low word
        i2.rd2[31] = 1'b1;
        i1.aluSrc  = n[1];
        runPair("wordOps", i1, i2, randBypass(), 0);
      end
    end

    foreach (fwdCodes[ia]) begin
      foreach (fwdCodes[ib]) begin
        i1 = randIssue(opAdd);
        i2 = randIssue(opSub);
        i1.fwdA   = fwdCodes[ia];
        i1.fwdB   = fwdCodes[ib];
        i2.fwdA   = fwdCodes[ib];
        i2.fwdB   = fwdCodes[ia];
        i1.aluSrc = ia[0];
        runPair("forwarding", i1, i2, randBypass(), 0);
      end
    end

    foreach (ctlOps[k]) begin
      for (int n = 0; n < 6; n++) begin
        i1 = randIssue(ctlOps[k]);
        i2 = randIssue(ctlOps[(k + 3) % 8]);
        i1.fwdA = fwdCodes[randBits(3) % 7];
        if (n < 2) begin
          i1.fwdB = i1.fwdA;  // equal operands
          i1.rd2  = i1.rd1;
        end
        runPair("branches", i1, i2, randBypass(), 0);
      end
    end

    repeat (4) begin
      runPair("combineBoth", randIssue(opJal), randIssue(opJalr), randBypass(), 0);
      runPair("combineLane2", randIssue(opXor), randIssue(opJal), randBypass(), 0);
      runPair("combineNone", randIssue(opOr), randIssue(opSltu), randBypass(), 0);
    end

    repeat (8) begin
      runPair("hold", randIssue(ctlOps[randBits(3)]), randIssue(fullOps[randBits(4) % 12]),
              randBypass(), 1 + randBits(2));
    end

    $display("checks %0d, mismatches %0d, timeouts %0d, property failures %0d",
             checkCount, mismatchCount, timeoutCount, dut_i.props_i.failCount);
    if (mismatchCount == 0 && timeoutCount == 0 && dut_i.props_i.failCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
execPkg.sv
laneAlu.sv
execLane.sv
branchResolve.sv
execStage.sv
execStage_props.sv
tbExecStage.sv
